// File: bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic arstN
);

	localparam int resetCycles = 16;

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1 arstN = 1'b1;                     // Release just after an edge.
	end

	always #50 clk = ~clk;                   // 100 ns period.

endmodule

`default_nettype wire

// File: bench/tbDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module tbDatapath
	import srcPkg::*;
();

	localparam int numVectors = 42;
	localparam int wordsPerVector = 5;       // Control, port, bus, load, drive.
	localparam int memDepth = numVectors * wordsPerVector;
	localparam int resetCycles = 16;
	localparam int timeoutCycles = numVectors + resetCycles + 10;

	typedef logic [$clog2(memDepth)-1:0] memAddr_t;

	logic clk;
	logic arstN;
	logic gra;
	logic grb;
	logic grc;
	logic rIn;
	logic rOut;
	logic baOut;
	logic cOut;
	logic pcOut;
	logic pcIn;
	logic incPc;
	logic irIn;
	logic yIn;
	logic zIn;
	logic zOut;
	logic inPortOut;
	aluOp_t aluOp;
	word_t inPortData;
	word_t busValue;
	regSel_t regLoad;
	regSel_t regDrive;

	word_t vectors [memDepth];
	int cycleCount;

	clockGen uClock (.clk(clk), .arstN(arstN));

	srcDatapath UUT (.*);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic stopWithFailure();
		$display("TEST FAILED");
		$fatal(1, "Stopped at the first failure.");
	endtask

	task automatic checkWord(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("ERR t=%0t %s got %h expected %h", $time, name, actual, expected);
			stopWithFailure();
		end
	endtask

	task automatic checkSel(input string name, input regSel_t actual, input regSel_t expected);
		if (actual !== expected) begin
			$display("ERR t=%0t %s got %h expected %h", $time, name, actual, expected);
			stopWithFailure();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic word_t vectorWord(input int line, input int column);
		return vectors[memAddr_t'(line * wordsPerVector + column)];
	endfunction

	// One hex digit per strobe group, weights 1, 2, 4, 8.
	task automatic applyControls(input word_t ctrl, input word_t portData);
		gra = ctrl[0];
		grb = ctrl[1];
		grc = ctrl[2];
		rIn = ctrl[3];
		rOut = ctrl[4];
		baOut = ctrl[5];
		cOut = ctrl[6];
		pcOut = ctrl[7];
		pcIn = ctrl[8];
		incPc = ctrl[9];
		irIn = ctrl[10];
		yIn = ctrl[11];
		zIn = ctrl[12];
		zOut = ctrl[13];
		inPortOut = ctrl[14];
		aluOp = aluOp_t'(ctrl[18:16]);
		inPortData = portData;
	endtask

	initial begin
		word_t ctrl;
		applyControls('0, '0);
		for (int i = 0; i < memDepth; i++) begin
			vectors[memAddr_t'(i)] = {12'hBAD, 20'(i)};
		end
		$readmemh("bench/testdata.txt", vectors);
		// Unused control bits stay clear in real data.
		for (int v = 0; v < numVectors; v++) begin
			ctrl = vectorWord(v, 0);
			if (ctrl[31:19] != '0) begin
				$display("Test data file bench/testdata.txt is missing or has too few lines.");
				stopWithFailure();
			end
		end
		wait (arstN === 1'b1);
		for (int v = 0; v < numVectors; v++) begin
			@(posedge clk);
			#1;
			applyControls(vectorWord(v, 0), vectorWord(v, 1));
			@(negedge clk);
			checkWord("busValue", busValue, vectorWord(v, 2));
			checkSel("regLoad", regLoad, regSel_t'(vectorWord(v, 3)));
			checkSel("regDrive", regDrive, regSel_t'(vectorWord(v, 4)));
		end
		$display("TEST PASSED");
		$finish;
	end

	// Watchdog.
	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d clock cycles before the test data was done.", cycleCount);
		stopWithFailure();
	end

endmodule

`default_nettype wire

// File: bench/testdata.txt
// Columns: ctrl inPortData busValue regLoad regDrive, one clock cycle per line.
// ctrl digits from the left: aluOp, zIn/zOut/inPortOut, pcIn/incPc/irIn/yIn, rOut/baOut/cOut/pcOut, gra/grb/grc/rIn (weights 1 2 4 8).
00000 00000000 00000000 0000 0000
04400 01AC8123 01AC8123 0000 0000
04009 12345678 12345678 0008 0000
0400A 33334444 33334444 0020 0000
0400C 55556666 55556666 0200 0000
00011 00000000 12345678 0000 0008
00012 00000000 33334444 0000 0020
00014 00000000 55556666 0000 0200
00013 00000000 12345678 0000 0008
00016 00000000 33334444 0000 0020
0400E 8421F0A5 8421F0A5 0020 0000
00012 00000000 8421F0A5 0000 0020
00014 00000000 55556666 0000 0200
00040 00000000 FFFC8123 0000 0000
04400 001A8456 001A8456 0000 0000
00040 00000000 00028456 0000 0000
04009 9999BBBB 9999BBBB 0001 0000
00011 00000000 9999BBBB 0000 0001
00021 00000000 00000000 0000 0001
00022 00000000 12345678 0000 0008
00812 00000000 12345678 0000 0008
01014 00000000 8421F0A5 0000 0020
02000 00000000 9656471D 0000 0000
11014 00000000 8421F0A5 0000 0020
02000 00000000 8E1265D3 0000 0000
21014 00000000 8421F0A5 0000 0020
02000 00000000 00205020 0000 0000
31014 00000000 8421F0A5 0000 0020
02000 00000000 9635F6FD 0000 0000
41014 00000000 8421F0A5 0000 0020
02000 00000000 0091A2B3 0000 0000
51014 00000000 8421F0A5 0000 0020
02000 00000000 468ACF00 0000 0000
61014 00000000 8421F0A5 0000 0020
02000 00000000 7BDE0F5B 0000 0000
71014 00000000 8421F0A5 0000 0020
02000 00000000 7BDE0F5A 0000 0000
04100 00001000 00001000 0000 0000
00280 00000000 00001000 0000 0000
00080 00000000 00001004 0000 0000
04300 00002000 00002000 0000 0000
00080 00000000 00002000 0000 0000

// File: run.sh
#!/bin/sh
# Build and run the datapath testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tbDatapath -f src.f

out=$(./obj_dir/VtbDatapath) || {
	echo "$out"
	exit 1
}
echo "$out"
if echo "$out" | grep -q "TEST PASSED"; then
	exit 0
fi
exit 1

// File: src.f
verilog/srcPkg.sv
verilog/selectEncode.sv
verilog/registerFile.sv
verilog/programRegisters.sv
verilog/aluUnit.sv
verilog/busMux.sv
verilog/srcDatapath.sv
bench/clockGen.sv
bench/tbDatapath.sv

// File: verilog/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit
	import srcPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic yIn,
	input logic zIn,
	input aluOp_t aluOp,
	input word_t busIn,
	output word_t z
);

	word_t y;
	word_t result;
	logic [shamtWidth-1:0] shamt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Y operand register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			y <= '0;
		end else if (yIn) begin
			y <= busIn;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign shamt = busIn[shamtWidth-1:0];

	always_comb begin
		result = '0;
		case (aluOp)
			opAdd: begin
				result = y + busIn;
			end
			opSub: begin
				result = y - busIn;
			end
			opAnd: begin
				result = y & busIn;
			end
			opOr: begin
				result = y | busIn;
			end
			opShr: begin
				result = y >> shamt;             // Logical shift.
			end
			opShl: begin
				result = y << shamt;
			end
			// Unary ops use the bus only.
			opNeg: begin
				result = -busIn;
			end
			opNot: begin
				result = ~busIn;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Z result register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			z <= '0;
		end else if (zIn) begin
			z <= result;
		end
	end

endmodule

`default_nettype wire

// File: verilog/busMux.sv
`timescale 1ns/1ps
`default_nettype none

module busMux
	import srcPkg::*;
(
	input word_t regData,
	input word_t z,
	input word_t pc,
	input word_t cSignExt,
	input word_t inPortData,
	input regSel_t regDrive,
	input logic zOut,
	input logic pcOut,
	input logic cOut,
	input logic inPortOut,
	output word_t busValue
);

	logic regOut;

	// Any register drive line claims the bus.
	assign regOut = |regDrive;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fixed priority source select.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		if (regOut) begin
			busValue = regData;
		end else if (zOut) begin
			busValue = z;
		end else if (pcOut) begin
			busValue = pc;
		end else if (cOut) begin
			busValue = cSignExt;
		end else if (inPortOut) begin
			busValue = inPortData;
		end else begin
			busValue = '0;                   // Idle bus.
		end
	end

endmodule

`default_nettype wire

// File: verilog/programRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module programRegisters
	import srcPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic pcIn,
	input logic incPc,
	input logic irIn,
	input word_t busIn,
	output word_t pc,
	output word_t ir
);

	localparam word_t pcStep = word_t'(4);   // One word per instruction.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Program counter.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (pcIn) begin
			pc <= busIn;                     // Bus load wins over increment.
		end else if (incPc) begin
			pc <= pc + pcStep;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ir <= '0;
		end else if (irIn) begin
			ir <= busIn;
		end
	end

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
	import srcPkg::*;
(
	input logic clk,
	input logic arstN,
	input regSel_t regLoad,
	input regSel_t regDrive,
	input logic baOut,
	input word_t busIn,
	output word_t regData
);

	word_t regs [numRegs];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write port.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < numRegs; i++) begin
				if (regLoad[i]) begin
					regs[i] <= busIn;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read port.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wired-OR of the driven registers, the way a shared bus would merge them.
	always_comb begin
		regData = '0;
		for (int i = 0; i < numRegs; i++) begin
			if (regDrive[i]) begin
				regData = regData | regs[i];
			end
		end
		// R0 reads as zero for base addressing.
		if (baOut && regDrive[0]) begin
			regData = '0;
			for (int i = 1; i < numRegs; i++) begin
				if (regDrive[i]) begin
					regData = regData | regs[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/selectEncode.sv
`timescale 1ns/1ps
`default_nettype none

module selectEncode
	import srcPkg::*;
(
	input word_t ir,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	output regSel_t regLoad,
	output regSel_t regDrive,
	output word_t cSignExt
);

	regIdx_t raField;
	regIdx_t rbField;
	regIdx_t rcField;
	regIdx_t selIdx;
	logic selValid;
	regSel_t oneHot;

	assign raField = ir[raMsb -: idxWidth];
	assign rbField = ir[rbMsb -: idxWidth];
	assign rcField = ir[rcMsb -: idxWidth];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field select, gra over grb over grc.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		selIdx = '0;
		selValid = 1'b0;
		if (gra) begin
			selIdx = raField;
			selValid = 1'b1;
		end else if (grb) begin
			selIdx = rbField;
			selValid = 1'b1;
		end else if (grc) begin
			selIdx = rcField;
			selValid = 1'b1;
		end
	end

	// Decode to one-hot, zero when no group is selected.
	always_comb begin
		oneHot = '0;
		if (selValid) begin
			oneHot = regSel_t'(1) << selIdx;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Load and drive lines.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign regLoad = rIn ? oneHot : '0;
	assign regDrive = (rOut | baOut) ? oneHot : '0;   // BAout also drives.

	// Sign-extended constant from ir[18:0].
	assign cSignExt = {{(wordWidth-constMsb-1){ir[constMsb]}}, ir[constMsb:0]};

endmodule

`default_nettype wire

// File: verilog/srcDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module srcDatapath
	import srcPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	input logic cOut,
	input logic pcOut,
	input logic pcIn,
	input logic incPc,
	input logic irIn,
	input logic yIn,
	input logic zIn,
	input logic zOut,
	input logic inPortOut,
	input aluOp_t aluOp,
	input word_t inPortData,
	output word_t busValue,
	output regSel_t regLoad,
	output regSel_t regDrive
);

	word_t ir;
	word_t pc;
	word_t z;
	word_t regData;
	word_t cSignExt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register select.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	selectEncode uSelect (
		.ir(ir), .gra(gra), .grb(grb), .grc(grc),
		.rIn(rIn), .rOut(rOut), .baOut(baOut),
		.regLoad(regLoad), .regDrive(regDrive), .cSignExt(cSignExt)
	);

	registerFile uRegs (
		.clk(clk), .arstN(arstN), .regLoad(regLoad), .regDrive(regDrive),
		.baOut(baOut), .busIn(busValue), .regData(regData)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// PC, IR and ALU.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	programRegisters uProgram (
		.clk(clk), .arstN(arstN), .pcIn(pcIn), .incPc(incPc), .irIn(irIn),
		.busIn(busValue), .pc(pc), .ir(ir)
	);

	aluUnit uAlu (
		.clk(clk), .arstN(arstN), .yIn(yIn), .zIn(zIn), .aluOp(aluOp),
		.busIn(busValue), .z(z)
	);

	// Bus sources.
	busMux uBus (
		.regData(regData), .z(z), .pc(pc), .cSignExt(cSignExt),
		.inPortData(inPortData), .regDrive(regDrive), .zOut(zOut),
		.pcOut(pcOut), .cOut(cOut), .inPortOut(inPortOut), .busValue(busValue)
	);

endmodule

`default_nettype wire

// File: verilog/srcPkg.sv
`default_nettype none

package srcPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int wordWidth = 32;
	localparam int idxWidth = 4;
	localparam int numRegs = 16;
	localparam int shamtWidth = 5;        // Shift amount from low bus bits.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction fields.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Each register field is idxWidth bits wide, ending at its MSB.
	localparam int raMsb = 26;
	localparam int rbMsb = 22;
	localparam int rcMsb = 18;
	localparam int constMsb = 18;         // Constant spans bits 18 to 0.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [wordWidth-1:0] word_t;
	typedef logic [idxWidth-1:0] regIdx_t;

	// Bit n selects Rn.
	typedef logic [numRegs-1:0] regSel_t;

	// ALU operations.
	typedef enum logic [2:0] {
		opAdd = 3'd0,
		opSub = 3'd1,
		opAnd = 3'd2,
		opOr = 3'd3,
		opShr = 3'd4,
		opShl = 3'd5,
		opNeg = 3'd6,
		opNot = 3'd7
	} aluOp_t;

endpackage

`default_nettype wire
